//--- Bender.yml
package:
  name: rs_issue

export_include_dirs:
  - .

sources:
  # design, in compile order
  - rs_pkg.sv
  - msb_psel_gen.sv
  - rs_entry_array.sv
  - issue_credit_counter.sv
  - rs_ctrl_fsm.sv
  - rs_issue_top.sv

  # testbench, top module rs_issue_tb
  - target: test
    include_dirs:
      - .
    files:
      - rs_issue_properties.sv
      - rs_issue_tb.sv

//--- issue_credit_counter.sv
`include "rs_defines.svh"

module issue_credit_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`ISSUE_WIDTH-1:0]  credit_return,
    input  rs_pkg::rs_gcnt_t         issued_count,
    input  logic                     issue_block,
    output rs_pkg::rs_gcnt_t         grant_limit,
    output logic                     credits_full
);

    import rs_pkg::*;

    rs_credit_t credit_q;
    rs_credit_t credit_d;

    // add returns, take away grants, clamp to pool depth
    always_comb begin : next_count
        int sum;
        sum = int'(credit_q) - int'(issued_count);
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            sum = sum + int'(credit_return[k]);
        end
        if (sum > `FU_CREDITS) begin
            credit_d = rs_credit_t'(`FU_CREDITS);
        end else if (sum < 0) begin
            credit_d = '0;
        end else begin
            credit_d = rs_credit_t'(sum);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_q <= rs_credit_t'(`FU_CREDITS);
        end else begin
            credit_q <= credit_d;
        end
    end

    // min(credits, issue width), nothing while drained
    always_comb begin
        if (issue_block) begin
            grant_limit = '0;
        end else if (int'(credit_q) >= `ISSUE_WIDTH) begin
            grant_limit = rs_gcnt_t'(`ISSUE_WIDTH);
        end else begin
            grant_limit = rs_gcnt_t'(credit_q);
        end
    end

    assign credits_full = (credit_q == rs_credit_t'(`FU_CREDITS));

endmodule

//--- msb_psel_gen.sv
// multi-grant selector, highest index first
// row 0 of gnt_bus holds the top request, row 1 the next, and so on
module msb_psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]      req,
    output logic [WIDTH-1:0]      gnt,
    output logic [WIDTH*REQS-1:0] gnt_bus,
    output logic                  empty
);

    // request seen by each stage
    logic [WIDTH*REQS-1:0] stage_req;

    assign empty = ~(|req);

    for (genvar j = 0; j < REQS; j++) begin : g_stage
        if (j == 0) begin : g_first
            assign stage_req[WIDTH-1:0] = req;
        end else begin : g_next
            // drop what the previous stage already took
            assign stage_req[j*WIDTH +: WIDTH] = stage_req[(j-1)*WIDTH +: WIDTH] &
                                                 ~gnt_bus[(j-1)*WIDTH +: WIDTH];
        end

        msb_sel #(
            .WIDTH(WIDTH)
        ) u_sel (
            .req(stage_req[j*WIDTH +: WIDTH]),
            .gnt(gnt_bus[j*WIDTH +: WIDTH])
        );
    end

    // union of all rows
    always_comb begin
        gnt = '0;
        for (int k = 0; k < REQS; k++) begin
            gnt = gnt | gnt_bus[k*WIDTH +: WIDTH];
        end
    end

endmodule

// one-hot grant of the highest set request bit
module msb_sel #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);

    logic [WIDTH-1:0] req_r;
    logic [WIDTH-1:0] gnt_r;
    // any lower-order reversed request already set
    logic [WIDTH-1:0] seen;

    // flip so the top bit becomes bit 0, then pick lowest
    for (genvar i = 0; i < WIDTH; i++) begin : g_rev
        assign req_r[WIDTH-1-i] = req[i];
        assign gnt[WIDTH-1-i]   = gnt_r[i];
    end

    assign seen[0] = 1'b0;
    for (genvar i = 1; i < WIDTH; i++) begin : g_chain
        assign seen[i] = seen[i-1] | req_r[i-1];
    end

    assign gnt_r = req_r & ~seen;

endmodule

//--- rs_ctrl_fsm.sv
module rs_ctrl_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              credits_full,
    output rs_pkg::rs_state_e state,
    output logic              issue_block,
    output logic              dispatch_block
);

    import rs_pkg::*;

    rs_state_e state_q;
    rs_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RS_RUN: begin
                if (flush) begin
                    state_d = RS_DRAIN;
                end
            end
            RS_DRAIN: begin
                // a second flush keeps us here
                // leave once every credit is back in the pool
                if (!flush && credits_full) begin
                    state_d = RS_RUN;
                end
            end
            default: begin
                state_d = RS_RUN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RS_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign state = state_q;

    // both sides held off while draining
    // registered only, so dispatch_ready stays flop-driven
    assign issue_block    = (state_q == RS_DRAIN);
    assign dispatch_block = (state_q == RS_DRAIN);

endmodule

//--- rs_defines.svh
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// slots in the reservation station
`define RS_ENTRIES 8

// grants per cycle toward the fu pool
`define ISSUE_WIDTH 2

// physical register tag width
`define TAG_BITS 6

// depth of the functional-unit pool
`define FU_CREDITS 4

`endif

//--- rs_entry_array.sv
`include "rs_defines.svh"

module rs_entry_array (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     alloc_en,
    input  rs_pkg::rs_entry_t                        alloc_entry,
    input  rs_pkg::rs_wakeup_t [`ISSUE_WIDTH-1:0]    wakeup,
    input  logic [`RS_ENTRIES-1:0]                   grant_mask,
    input  logic                                     flush,
    output logic [`RS_ENTRIES-1:0]                   ready_vec,
    output logic                                     has_free,
    output rs_pkg::rs_entry_t [`RS_ENTRIES-1:0]      slot_entry
);

    import rs_pkg::*;

    // payload, no reset needed
    rs_entry_t [`RS_ENTRIES-1:0] slot_q;

    // per-slot control
    logic [`RS_ENTRIES-1:0] valid_q;
    logic [`RS_ENTRIES-1:0] rdy1_q;
    logic [`RS_ENTRIES-1:0] rdy2_q;

    // wakeup hits this cycle
    logic [`RS_ENTRIES-1:0] wake1;
    logic [`RS_ENTRIES-1:0] wake2;
    logic                   alloc_wake1;
    logic                   alloc_wake2;

    // one-hot target of the dispatch
    logic [`RS_ENTRIES-1:0] alloc_oh;

    // any broadcast carrying this tag
    function automatic logic tag_woken(input rs_tag_t tag,
                                       input rs_wakeup_t [`ISSUE_WIDTH-1:0] wk);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < `ISSUE_WIDTH; w++) begin
            if (wk[w].valid && (wk[w].tag == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // mem ops carry an offset in the src2 field, never waits on it
    function automatic logic src2_woken(input rs_entry_t e,
                                        input rs_wakeup_t [`ISSUE_WIDTH-1:0] wk);
        return e.is_mem | tag_woken(e.op.alu.src2, wk);
    endfunction

    // src1 lies at the same bits in both formats
    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            wake1[i] = tag_woken(slot_q[i].op.alu.src1, wakeup);
            wake2[i] = src2_woken(slot_q[i], wakeup);
        end
        alloc_wake1 = tag_woken(alloc_entry.op.alu.src1, wakeup);
        alloc_wake2 = src2_woken(alloc_entry, wakeup);
    end

    // lowest free slot
    always_comb begin : find_free
        logic found;
        found    = 1'b0;
        alloc_oh = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (!valid_q[i] && !found) begin
                alloc_oh[i] = alloc_en;
                found       = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            rdy1_q  <= '0;
            rdy2_q  <= '0;
        end else if (flush) begin
            // whole station dropped, ready bits rewritten on next alloc
            valid_q <= '0;
        end else begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (alloc_oh[i]) begin
                    // fresh sources start not ready unless woken right now
                    valid_q[i] <= 1'b1;
                    rdy1_q[i]  <= alloc_wake1;
                    rdy2_q[i]  <= alloc_wake2;
                end else begin
                    if (grant_mask[i]) begin
                        valid_q[i] <= 1'b0;
                    end
                    if (wake1[i]) begin
                        rdy1_q[i] <= 1'b1;
                    end
                    if (wake2[i]) begin
                        rdy2_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (alloc_oh[i]) begin
                slot_q[i] <= alloc_entry;
            end
        end
    end

    assign ready_vec  = valid_q & rdy1_q & rdy2_q;
    assign has_free   = ~(&valid_q);
    assign slot_entry = slot_q;

endmodule

//--- rs_issue_properties.sv
`include "rs_defines.svh"

module rs_issue_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`ISSUE_WIDTH-1:0] issue_valid,
    input logic                    dispatch_ready,
    input rs_pkg::rs_gcnt_t        grant_limit,
    input rs_pkg::rs_state_e       state,
    input rs_pkg::rs_credit_t      credit
);

    import rs_pkg::*;

    // failures seen so far, read by the testbench
    int assert_fails = 0;

    // zero limit this cycle, nothing registered next cycle
    no_issue_at_zero_limit: assert property (@(posedge clk) disable iff (!rst_n)
        (grant_limit == '0) |=> (issue_valid == '0))
        else begin
            $error("issue with zero grant limit");
            assert_fails++;
        end

    // lanes fill from slot 0 up
    lane_order: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid[1] |-> issue_valid[0])
        else begin
            $error("issue lane 1 without lane 0");
            assert_fails++;
        end

    no_dispatch_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
        (state == RS_DRAIN) |-> !dispatch_ready)
        else begin
            $error("dispatch_ready high while draining");
            assert_fails++;
        end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credit) <= `FU_CREDITS)
        else begin
            $error("credit count above pool depth");
            assert_fails++;
        end

endmodule

bind rs_issue_top rs_issue_properties u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid   (issue_valid),
    .dispatch_ready(dispatch_ready),
    .grant_limit   (grant_limit),
    .state         (u_fsm.state_q),
    .credit        (u_credit.credit_q)
);

//--- rs_issue_tb.sv
`include "rs_defines.svh"

module rs_issue_tb;

    import rs_pkg::*;

    localparam int TIMEOUT = 40;
    localparam logic [`ISSUE_WIDTH-1:0] LANE0 = {{(`ISSUE_WIDTH-1){1'b0}}, 1'b1};

    logic                          clk;
    logic                          rst_n;
    logic                          dispatch_valid;
    rs_entry_t                     dispatch_entry;
    rs_wakeup_t [`ISSUE_WIDTH-1:0] wakeup;
    logic [`ISSUE_WIDTH-1:0]       credit_return;
    logic                          flush;
    logic                          dispatch_ready;
    logic [`ISSUE_WIDTH-1:0]       issue_valid;
    rs_entry_t [`ISSUE_WIDTH-1:0]  issue_entry;

    integer seed;
    int     errors;
    int     checks;
    int     mark;

    // reference model of slots, ready bits and credits
    rs_entry_t              m_entry [`RS_ENTRIES];
    logic [`RS_ENTRIES-1:0] m_valid;
    logic [`RS_ENTRIES-1:0] m_rdy1;
    logic [`RS_ENTRIES-1:0] m_rdy2;
    int                     m_credits;
    logic                   m_drain;
    // outputs expected after the coming edge
    logic [`ISSUE_WIDTH-1:0] exp_valid;
    rs_entry_t               exp_entry [`ISSUE_WIDTH];
    logic                    exp_ready;

    rs_issue_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .dispatch_valid(dispatch_valid),
        .dispatch_entry(dispatch_entry),
        .wakeup        (wakeup),
        .credit_return (credit_return),
        .flush         (flush),
        .dispatch_ready(dispatch_ready),
        .issue_valid   (issue_valid),
        .issue_entry   (issue_entry)
    );

    always #50 clk = ~clk;

    task automatic check_entry(input string name, input rs_entry_t got, input rs_entry_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_valid_vec(input string name, input logic [`ISSUE_WIDTH-1:0] got,
                                   input logic [`ISSUE_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // bit 0 src1 seen on the bus, bit 1 src2 seen or not a register
    function automatic logic [1:0] wake_bits(input rs_entry_t e);
        rs_tag_t   s1;
        logic [1:0] hit;
        // src1 lies at the same bits in both formats
        s1  = e.op.alu.src1;
        hit = {e.is_mem, 1'b0};
        for (int w = 0; w < `ISSUE_WIDTH; w++) begin
            if (wakeup[w].valid && wakeup[w].tag == s1) hit[0] = 1'b1;
            if (wakeup[w].valid && !e.is_mem && wakeup[w].tag == e.op.alu.src2) hit[1] = 1'b1;
        end
        return hit;
    endfunction

    // advance the model by one edge using the inputs now driven
    task automatic model_edge();
        logic [`RS_ENTRIES-1:0] rdy;
        logic [`RS_ENTRIES-1:0] granted;
        logic [1:0]             wb;
        int                     limit;
        int                     n;
        int                     ret;
        int                     slot;
        rdy     = m_valid & m_rdy1 & m_rdy2;
        limit   = m_drain ? 0 : ((m_credits < `ISSUE_WIDTH) ? m_credits : `ISSUE_WIDTH);
        slot    = -1;
        n       = 0;
        ret     = 0;
        granted = '0;
        exp_valid = '0;
        if (dispatch_valid && !m_drain) begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (!m_valid[i] && slot < 0) slot = i;
            end
        end
        // highest ready index goes out first
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (rdy[i] && n < limit) begin
                granted[i]   = 1'b1;
                exp_valid[n] = 1'b1;
                exp_entry[n] = m_entry[i];
                n++;
            end
        end
        for (int k = 0; k < `ISSUE_WIDTH; k++) ret += int'(credit_return[k]);
        // drain exit looks at the credits before this edge
        if (!m_drain && flush) m_drain = 1'b1;
        else if (m_drain && !flush && m_credits == `FU_CREDITS) m_drain = 1'b0;
        m_credits = m_credits - n + ret;
        if (m_credits > `FU_CREDITS) m_credits = `FU_CREDITS;
        if (m_credits < 0) m_credits = 0;
        if (flush) begin
            m_valid = '0;
        end else begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                wb        = wake_bits(m_entry[i]);
                m_rdy1[i] = m_rdy1[i] | (m_valid[i] & wb[0]);
                m_rdy2[i] = m_rdy2[i] | (m_valid[i] & wb[1]);
            end
            m_valid = m_valid & ~granted;
            if (slot >= 0) begin
                wb            = wake_bits(dispatch_entry);
                m_valid[slot] = 1'b1;
                m_entry[slot] = dispatch_entry;
                m_rdy1[slot]  = wb[0];
                m_rdy2[slot]  = wb[1];
            end
        end
        exp_ready = !m_drain && !(&m_valid);
    endtask

    // one clock, compare outputs, release one-shot inputs
    task automatic tick();
        model_edge();
        @(posedge clk);
        #10;
        check_valid_vec("issue_valid", issue_valid, exp_valid);
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            if (exp_valid[k]) check_entry($sformatf("issue_entry[%0d]", k), issue_entry[k],
                                          exp_entry[k]);
        end
        check_bit("dispatch_ready", dispatch_ready, exp_ready);
        dispatch_valid = 1'b0;
        wakeup         = '0;
        credit_return  = '0;
        flush          = 1'b0;
    endtask

    function automatic rs_entry_t make_op(input logic is_mem, input rs_tag_t s1,
                                          input rs_tag_t s2);
        rs_entry_t e;
        e.is_mem        = is_mem;
        e.op.alu.opcode = 4'($random(seed));
        e.op.alu.dst    = rs_tag_t'($random(seed));
        e.op.alu.src1   = s1;
        e.op.alu.src2   = s2;
        return e;
    endfunction

    task automatic send(input rs_entry_t e);
        int t;
        t = 0;
        while (!dispatch_ready && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (!dispatch_ready) begin
            $display("%0t: dispatch_ready never came back, op dropped", $time);
            errors++;
        end else begin
            dispatch_valid = 1'b1;
            dispatch_entry = e;
        end
        tick();
    endtask

    task automatic broadcast(input rs_tag_t t0, input rs_tag_t t1);
        wakeup[0].valid = 1'b1;
        wakeup[0].tag   = t0;
        wakeup[1].valid = 1'b1;
        wakeup[1].tag   = t1;
        tick();
    endtask

    task automatic wait_issue(input string what);
        int t;
        t = 0;
        while (!issue_valid[0] && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (!issue_valid[0]) begin
            $display("%0t: no issue seen for %s before the timeout", $time, what);
            errors++;
        end
    endtask

    // hand back n credits on the return lanes
    task automatic give_back(input int n);
        for (int k = 0; k < `ISSUE_WIDTH; k++) credit_return[k] = (k < n);
    endtask

    // empty the station and refill the pool
    task automatic settle();
        int t;
        t = 0;
        while ((|m_valid || m_credits != `FU_CREDITS || m_drain) && t < TIMEOUT) begin
            give_back(`FU_CREDITS - m_credits);
            tick();
            t++;
        end
        if (|m_valid || m_credits != `FU_CREDITS || m_drain) begin
            $display("%0t: station did not drain before the timeout", $time);
            errors++;
        end
    endtask

    task automatic test_reset();
        check_valid_vec("issue_valid", issue_valid, '0);
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
    endtask

    task automatic test_single();
        rs_entry_t e;
        e = make_op(1'b0, 6'h05, 6'h06);
        send(e);
        broadcast(6'h05, 6'h06);
        // ready now, out on the next edge
        check_valid_vec("issue_valid", issue_valid, '0);
        tick();
        check_valid_vec("issue_valid", issue_valid, LANE0);
        check_entry("issue_entry[0]", issue_entry[0], e);
        settle();
    endtask

    task automatic test_priority();
        int t;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            send(make_op(1'b0, 6'h20 | 6'($random(seed) & 1), 6'h22 | 6'($random(seed) & 1)));
        end
        check_bit("dispatch_ready", dispatch_ready, 1'b0);
        // first pair readies nothing, second readies all eight
        broadcast(6'h20, 6'h21);
        broadcast(6'h22, 6'h23);
        t = 0;
        while (|m_valid && t < TIMEOUT) begin
            credit_return = issue_valid;
            tick();
            t++;
        end
        if (|m_valid) begin
            $display("%0t: full station never emptied", $time);
            errors++;
        end
        settle();
    endtask

    task automatic test_union();
        rs_entry_t m;
        rs_entry_t a;
        m        = make_op(1'b1, 6'h11, 6'h12);
        a        = m;
        a.is_mem = 1'b0;
        send(m);
        send(a);
        // only the base register is broadcast
        broadcast(6'h11, 6'h11);
        wait_issue("memory op");
        check_entry("issue_entry[0]", issue_entry[0], m);
        for (int c = 0; c < 3; c++) begin
            tick();
            check_valid_vec("issue_valid", issue_valid, '0);
        end
        broadcast(6'h12, 6'h12);
        wait_issue("alu op");
        check_entry("issue_entry[0]", issue_entry[0], a);
        settle();
    endtask

    task automatic test_backpressure();
        int seen;
        int t;
        seen = 0;
        for (int i = 0; i < 6; i++) send(make_op(1'b0, 6'h30, 6'h31));
        broadcast(6'h30, 6'h31);
        for (int c = 0; c < 8; c++) begin
            tick();
            for (int k = 0; k < `ISSUE_WIDTH; k++) seen += int'(issue_valid[k]);
        end
        checks++;
        if (seen != `FU_CREDITS) begin
            $display("Mismatch at time %0t: issue_valid count is %0d, expected %0d", $time,
                     seen, `FU_CREDITS);
            errors++;
        end
        t = 0;
        while (|m_valid && t < TIMEOUT) begin
            credit_return = LANE0;
            tick();
            t++;
        end
        if (|m_valid) begin
            $display("%0t: held ops never issued after credits came back", $time);
            errors++;
        end
        settle();
    endtask

    task automatic test_flush();
        rs_entry_t e;
        int        seen;
        int        back;
        int        t;
        seen = 0;
        back = 0;
        t    = 0;
        for (int i = 0; i < `FU_CREDITS; i++) send(make_op(1'b0, 6'h38, 6'h39));
        broadcast(6'h38, 6'h39);
        while (seen < `FU_CREDITS && t < TIMEOUT) begin
            tick();
            for (int k = 0; k < `ISSUE_WIDTH; k++) seen += int'(issue_valid[k]);
            t++;
        end
        if (seen < `FU_CREDITS) begin
            $display("%0t: pool was not used up before the flush", $time);
            errors++;
        end
        // these sit ready with an empty pool
        for (int i = 0; i < 3; i++) send(make_op(1'b0, 6'h3a, 6'h3b));
        broadcast(6'h3a, 6'h3b);
        flush = 1'b1;
        tick();
        check_bit("dispatch_ready", dispatch_ready, 1'b0);
        t = 0;
        while (!dispatch_ready && t < TIMEOUT) begin
            if (back < `FU_CREDITS) begin
                credit_return = LANE0;
                back++;
            end
            tick();
            t++;
        end
        if (!dispatch_ready || back < `FU_CREDITS) begin
            $display("%0t: drain ended wrongly, %0d credits returned", $time, back);
            errors++;
        end
        e = make_op(1'b0, 6'h3c, 6'h3d);
        send(e);
        broadcast(6'h3c, 6'h3d);
        wait_issue("op after flush");
        check_entry("issue_entry[0]", issue_entry[0], e);
        settle();
    endtask

    task automatic report(input string name);
        if (errors == mark) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - mark);
        mark = errors;
    endtask

    initial begin
        seed           = 42;
        errors         = 0;
        checks         = 0;
        mark           = 0;
        clk            = 1'b0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_entry = '0;
        wakeup         = '0;
        credit_return  = '0;
        flush          = 1'b0;
        m_valid        = '0;
        m_rdy1         = '0;
        m_rdy2         = '0;
        m_credits      = `FU_CREDITS;
        m_drain        = 1'b0;
        for (int i = 0; i < `RS_ENTRIES; i++) m_entry[i] = '0;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        test_reset();
        report("reset state");
        test_single();
        report("single issue");
        test_priority();
        report("highest-index priority");
        test_union();
        report("union decode");
        test_backpressure();
        report("credit back-pressure");
        test_flush();
        report("flush and drain");
        errors = errors + dut_i.u_props.assert_fails;
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- rs_issue_top.f
+incdir+.
rs_pkg.sv
msb_psel_gen.sv
rs_entry_array.sv
issue_credit_counter.sv
rs_ctrl_fsm.sv
rs_issue_top.sv
rs_issue_properties.sv
rs_issue_tb.sv

//--- rs_issue_top.sv
`include "rs_defines.svh"

module rs_issue_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   dispatch_valid,
    input  rs_pkg::rs_entry_t                      dispatch_entry,
    input  rs_pkg::rs_wakeup_t [`ISSUE_WIDTH-1:0]  wakeup,
    input  logic [`ISSUE_WIDTH-1:0]                credit_return,
    input  logic                                   flush,
    output logic                                   dispatch_ready,
    output logic [`ISSUE_WIDTH-1:0]                issue_valid,
    output rs_pkg::rs_entry_t [`ISSUE_WIDTH-1:0]   issue_entry
);

    import rs_pkg::*;

    logic                               alloc_en;
    logic [`RS_ENTRIES-1:0]             ready_vec;
    logic                               has_free;
    rs_entry_t [`RS_ENTRIES-1:0]        slot_entry;
    logic [`RS_ENTRIES*`ISSUE_WIDTH-1:0] gnt_bus;
    logic [`RS_ENTRIES-1:0]             grant_mask;
    rs_gcnt_t                           grant_limit;
    rs_gcnt_t                           issued_count;
    logic                               credits_full;
    logic                               issue_block;
    logic                               dispatch_block;

    // per issue slot, grant survives the credit limit
    logic [`ISSUE_WIDTH-1:0]            take;
    rs_entry_t [`ISSUE_WIDTH-1:0]       issue_sel;

    assign dispatch_ready = has_free & ~dispatch_block;
    assign alloc_en       = dispatch_valid & dispatch_ready;

    rs_entry_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_en   (alloc_en),
        .alloc_entry(dispatch_entry),
        .wakeup     (wakeup),
        .grant_mask (grant_mask),
        .flush      (flush),
        .ready_vec  (ready_vec),
        .has_free   (has_free),
        .slot_entry (slot_entry)
    );

    // row 0 is the highest ready index
    msb_psel_gen #(
        .WIDTH(`RS_ENTRIES),
        .REQS (`ISSUE_WIDTH)
    ) u_psel (
        .req    (ready_vec),
        .gnt    (),
        .gnt_bus(gnt_bus),
        .empty  ()
    );

    // rows below grant_limit go out, the rest wait
    always_comb begin : grant_comb
        logic [`RS_ENTRIES-1:0] row;
        grant_mask   = '0;
        issued_count = '0;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            row          = gnt_bus[k*`RS_ENTRIES +: `RS_ENTRIES];
            take[k]      = (k < int'(grant_limit)) && (|row);
            issue_sel[k] = '0;
            if (take[k]) begin
                grant_mask   = grant_mask | row;
                issued_count = issued_count + rs_gcnt_t'(1);
            end
            // one-hot row picks the slot payload
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (row[i]) begin
                    issue_sel[k] = slot_entry[i];
                end
            end
        end
    end

    issue_credit_counter u_credit (
        .clk          (clk),
        .rst_n        (rst_n),
        .credit_return(credit_return),
        .issued_count (issued_count),
        .issue_block  (issue_block),
        .grant_limit  (grant_limit),
        .credits_full (credits_full)
    );

    // state itself only watched from outside
    rs_ctrl_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .credits_full  (credits_full),
        .state         (),
        .issue_block   (issue_block),
        .dispatch_block(dispatch_block)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= '0;
        end else begin
            issue_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        issue_entry <= issue_sel;
    end

endmodule

//--- rs_pkg.sv
`include "rs_defines.svh"

package rs_pkg;

    // physical register tag
    typedef logic [`TAG_BITS-1:0] rs_tag_t;

    // credit count, holds 0 up to FU_CREDITS
    typedef logic [$clog2(`FU_CREDITS+1)-1:0] rs_credit_t;

    // grant count, holds 0 up to ISSUE_WIDTH
    typedef logic [$clog2(`ISSUE_WIDTH+1)-1:0] rs_gcnt_t;

    // alu op, two register sources
    typedef struct packed {
        logic [3:0] opcode;
        rs_tag_t    dst;
        rs_tag_t    src1;
        rs_tag_t    src2;
    } rs_alu_fmt_t;

    // memory op, src1 is the base, last field is an immediate
    typedef struct packed {
        logic [3:0] opcode;
        rs_tag_t    dst;
        rs_tag_t    src1;
        rs_tag_t    offset;
    } rs_mem_fmt_t;

    // same bits, two readings
    typedef union packed {
        rs_alu_fmt_t alu;
        rs_mem_fmt_t mem;
    } rs_op_u;

    // dispatch and issue payload
    typedef struct packed {
        logic   is_mem;
        rs_op_u op;
    } rs_entry_t;

    // one broadcast on the wakeup bus
    typedef struct packed {
        logic    valid;
        rs_tag_t tag;
    } rs_wakeup_t;

    typedef enum logic {
        RS_RUN   = 1'b0,
        RS_DRAIN = 1'b1
    } rs_state_e;

endpackage
